/* flist.f */
+incdir+hw
hw/tmip_pkg.sv
hw/gray_convert.sv
hw/frame_store.sv
hw/conv_engine.sv
hw/result_serializer.sv
hw/tmip_top.sv
sim/tb_tmip.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs tb_tmip with Verilator; exits non-zero on any failure
set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_tmip \
	-Mdir "$BUILD_DIR" -o tb_tmip_sim -f flist.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/tb_tmip_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -Fqx '>>> PASS' "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* sim/tb_tmip.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_tmip;

	localparam int SEED = 32'h49a6_dec3;
	// each action gets edge^2 x 60 cycles, plus margin for reset and idle gaps
	localparam int WATCHDOG_CYCLES = (16 + 3 * 64 + 256 + 16) * 60 + 200;

	logic clk = 1'b0;
	logic rst_n, in_valid, in_valid2;
	tmip_pkg::pixel_t image, template;
	logic [1:0] image_size;
	logic [2:0] action;
	logic out_valid, out_value;

	int img_r [256];
	int img_g [256];
	int img_b [256];
	int tmpl [9];
	int exp_q [$];
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int words_seen = 0;
	int valid_cycles = 0;
	int bit_cnt = 0;
	logic [19:0] word = '0;

	tmip_top dut_i (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_valid2(in_valid2),
		.image(image), .template(template), .image_size(image_size), .action(action),
		.out_valid(out_valid), .out_value(out_value)
	);

	always #2 clk = ~clk;

	// ========================================
	// reference model
	// ========================================
	function automatic int gray_of(int idx, tmip_pkg::gray_mode_e mode, bit neg);
		int r, g, b, v;
		r = img_r[idx];
		g = img_g[idx];
		b = img_b[idx];
		case (mode)
			tmip_pkg::GRAY_MAX: v = (r > g) ? ((r > b) ? r : b) : ((g > b) ? g : b);
			tmip_pkg::GRAY_AVG: v = (r + g + b) / 3;
			default: v = (r >> 2) + (g >> 1) + (b >> 2);
		endcase
		return neg ? 255 - v : v;
	endfunction

	function automatic int expected_at(int x, int y, int edge_len,
		tmip_pkg::gray_mode_e mode, bit neg);
		int sum, px, py;
		sum = 0;
		for (int dy = -1; dy <= 1; dy++) begin
			for (int dx = -1; dx <= 1; dx++) begin
				px = x + dx;
				py = y + dy;
				// zero padding outside the image
				if (px >= 0 && px < edge_len && py >= 0 && py < edge_len) begin
					sum += gray_of(py * edge_len + px, mode, neg) * tmpl[(dy + 1) * 3 + dx + 1];
				end
			end
		end
		return sum;
	endfunction

	// ========================================
	// compare process
	// ========================================
	always @(negedge clk) begin
		int exp_v;
		if (!out_valid && out_value) begin
			$display("[FAIL] %0t out_value: expected 0, got 1", $time);
			errors++;
		end
		if (out_valid) begin
			word = {word[18:0], out_value};
			bit_cnt++;
			valid_cycles++;
			if (bit_cnt == 20) begin
				bit_cnt = 0;
				words_seen++;
				if (exp_q.size() == 0) begin
					$display("%0t result word arrived with no action pending", $time);
					errors++;
				end else begin
					exp_v = exp_q.pop_front();
					if (int'(word) != exp_v) begin
						$display("[FAIL] %0t out_value word: expected %0d, got %0d",
							$time, exp_v, word);
						errors++;
					end
				end
			end
		end else if (bit_cnt != 0) begin
			$display("%0t out_valid fell after %0d bits of a word", $time, bit_cnt);
			errors++;
			bit_cnt = 0;
		end
	end

	task automatic load_image(int size_code, bit all_max);
		int edge_len;
		edge_len = 4 << size_code;
		for (int i = 0; i < 9; i++) begin
			tmpl[i] = all_max ? 255 : int'($urandom_range(255));
		end
		for (int i = 0; i < edge_len * edge_len; i++) begin
			img_r[i] = all_max ? 255 : int'($urandom_range(255));
			img_g[i] = all_max ? 255 : int'($urandom_range(255));
			img_b[i] = all_max ? 255 : int'($urandom_range(255));
		end
		for (int i = 0; i < edge_len * edge_len * 3; i++) begin
			@(negedge clk);
			in_valid = 1'b1;
			image_size = 2'(size_code);
			template = (i < 9) ? tmip_pkg::pixel_t'(tmpl[i]) : '0;
			case (i % 3)
				0: image = tmip_pkg::pixel_t'(img_r[i / 3]);
				1: image = tmip_pkg::pixel_t'(img_g[i / 3]);
				default: image = tmip_pkg::pixel_t'(img_b[i / 3]);
			endcase
		end
		@(negedge clk);
		in_valid = 1'b0;
		image = '0;
		template = '0;
		// last plane write lands two cycles later
		repeat (4) @(negedge clk);
	endtask

	task automatic run_action(int edge_len, tmip_pkg::gray_mode_e mode, bit neg);
		int target, start_cycles, waited;
		for (int y = 0; y < edge_len; y++) begin
			for (int x = 0; x < edge_len; x++) begin
				exp_q.push_back(expected_at(x, y, edge_len, mode, neg));
			end
		end
		target = words_seen + edge_len * edge_len;
		start_cycles = valid_cycles;
		@(negedge clk);
		in_valid2 = 1'b1;
		action = {neg, mode};
		@(negedge clk);
		in_valid2 = 1'b0;
		action = '0;
		waited = 0;
		while (words_seen < target && waited < edge_len * edge_len * 60) begin
			@(posedge clk);
			waited++;
		end
		if (words_seen < target) begin
			$display("%0t action timed out with %0d of %0d words received", $time,
				edge_len * edge_len - (target - words_seen), edge_len * edge_len);
			errors++;
			exp_q.delete();
		end
		// no further valid bit may follow the last word
		repeat (40) @(negedge clk);
		if (valid_cycles - start_cycles != edge_len * edge_len * 20) begin
			$display("[FAIL] %0t out_valid cycles: expected %0d, got %0d", $time,
				edge_len * edge_len * 20, valid_cycles - start_cycles);
			errors++;
		end
	endtask

	task automatic report_test(string name, int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
		end
	endtask

	initial begin
		int mark;
		void'($urandom(SEED));
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_valid2 = 1'b0;
		image = '0;
		template = '0;
		image_size = '0;
		action = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		mark = errors;
		repeat (40) @(negedge clk);
		if (words_seen != 0 || valid_cycles != 0) begin
			$display("%0t output activity seen with no action sent", $time);
			errors++;
		end
		report_test("idle after reset", mark);

		mark = errors;
		load_image(0, 1'b0);
		run_action(4, tmip_pkg::GRAY_MAX, 1'b0);
		report_test("4x4 max plane", mark);

		mark = errors;
		load_image(1, 1'b0);
		run_action(8, tmip_pkg::GRAY_AVG, 1'b0);
		run_action(8, tmip_pkg::GRAY_WGT, 1'b0);
		run_action(8, tmip_pkg::GRAY_MAX, 1'b0);
		report_test("8x8 three planes", mark);

		mark = errors;
		load_image(2, 1'b0);
		run_action(16, tmip_pkg::GRAY_WGT, 1'b1);
		report_test("16x16 negated weighted", mark);

		mark = errors;
		load_image(0, 1'b1);
		run_action(4, tmip_pkg::GRAY_MAX, 1'b0);
		report_test("all 255 full scale", mark);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 4);
		$display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* hw/tmip_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tmip_config.svh"

module tmip_top (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic             in_valid2,
	input  tmip_pkg::pixel_t image,
	input  tmip_pkg::pixel_t template,
	input  logic [1:0]       image_size,
	input  logic [2:0]       action,
	output logic             out_valid,
	output logic             out_value
);

	logic in_valid_q;
	logic [4:0] edge_dec, img_edge;
	tmip_pkg::gray_set_t gray;
	logic wr_en;
	tmip_pkg::addr_t wr_addr;
	tmip_pkg::action_t act;
	logic rd_en;
	tmip_pkg::addr_t rd_addr;
	tmip_pkg::pixel_t rd_data;
	logic result_busy, result_load;
	tmip_pkg::conv_t result;

	// size code 0/1/2 -> 4/8/16
	always_comb begin
		case (image_size)
			2'd0: edge_dec = 5'(`TMIP_MAX_EDGE / 4);
			2'd1: edge_dec = 5'(`TMIP_MAX_EDGE / 2);
			default: edge_dec = 5'(`TMIP_MAX_EDGE);
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_valid_q <= 1'b0;
			img_edge <= 5'(`TMIP_MAX_EDGE / 4);
		end else begin
			in_valid_q <= in_valid;
			if (in_valid && !in_valid_q) begin
				img_edge <= edge_dec;
			end
		end
	end

	gray_convert u_gray (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .image(image),
		.img_edge(img_edge), .gray(gray), .wr_en(wr_en), .wr_addr(wr_addr)
	);

	frame_store u_store (
		.clk(clk), .gray(gray), .wr_en(wr_en), .wr_addr(wr_addr), .act(act),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
	);

	conv_engine u_conv (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .template(template),
		.in_valid2(in_valid2), .action(action), .img_edge(img_edge), .act(act),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.result_busy(result_busy), .result_load(result_load), .result(result)
	);

	result_serializer u_ser (
		.clk(clk), .rst_n(rst_n), .result_load(result_load), .result(result),
		.result_busy(result_busy), .out_valid(out_valid), .out_value(out_value)
	);

endmodule

`default_nettype wire

/* hw/result_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tmip_config.svh"

module result_serializer (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            result_load,
	input  tmip_pkg::conv_t result,
	output logic            result_busy,
	output logic            out_valid,
	output logic            out_value
);

	localparam int LAST_BIT = `TMIP_CONV_W - 1;

	tmip_pkg::conv_t shift_q;
	logic [4:0] bit_cnt;
	logic active;

	assign result_busy = active;
	assign out_valid = active;
	assign out_value = active & shift_q[LAST_BIT];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			bit_cnt <= '0;
		end else if (result_load) begin
			active <= 1'b1;
			bit_cnt <= '0;
		end else if (active) begin
			active <= (bit_cnt != 5'(LAST_BIT));
			bit_cnt <= bit_cnt + 5'd1;
		end
	end

	// msb first
	always_ff @(posedge clk) begin
		if (result_load) begin
			shift_q <= result;
		end else if (active) begin
			shift_q <= shift_q << 1;
		end
	end

	a_no_load_busy: assert property (@(posedge clk) disable iff (!rst_n)
		!(result_load && result_busy));

endmodule

`default_nettype wire

/* hw/conv_engine.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tmip_config.svh"

module conv_engine (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  tmip_pkg::pixel_t  template,
	input  logic              in_valid2,
	input  logic [2:0]        action,
	input  logic [4:0]        img_edge,
	output tmip_pkg::action_t act,
	output logic              rd_en,
	output tmip_pkg::addr_t   rd_addr,
	input  tmip_pkg::pixel_t  rd_data,
	input  logic              result_busy,
	output logic              result_load,
	output tmip_pkg::conv_t   result
);

	tmip_pkg::scan_state_e state;
	tmip_pkg::pixel_t tmpl [`TMIP_TAPS];
	tmip_pkg::pixel_t wt_d;
	tmip_pkg::conv_t acc;
	logic [3:0] tcnt;
	logic [3:0] tap_idx;
	logic [4:0] x, y;
	logic [1:0] trow, tcol;
	logic [5:0] px, py;
	logic [8:0] pix_cnt;
	logic drain;
	logic in_img;
	logic tap_vld;
	logic x_last, y_last;

	// ========================================
	// window geometry
	// ========================================
	// -1 wraps to 63, so one compare covers both borders
	assign px = {1'b0, x} + {4'b0000, tcol} - 6'd1;
	assign py = {1'b0, y} + {4'b0000, trow} - 6'd1;
	assign in_img = (px < {1'b0, img_edge}) && (py < {1'b0, img_edge});
	assign tap_idx = {2'b00, trow} * 4'd3 + {2'b00, tcol};
	assign x_last = (x == img_edge - 5'd1);
	assign y_last = (y == img_edge - 5'd1);
	assign pix_cnt = {4'b0000, img_edge} * {4'b0000, img_edge};

	assign rd_en = (state == tmip_pkg::SCAN_READ) && !drain && in_img;
	assign rd_addr = tmip_pkg::addr_t'(py) * tmip_pkg::addr_t'(img_edge)
		+ tmip_pkg::addr_t'(px);

	assign result_load = (state == tmip_pkg::SCAN_HOLD) && !result_busy;
	assign result = acc;

	// first nine image cycles carry the weights
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tcnt <= '0;
		end else if (!in_valid) begin
			tcnt <= '0;
		end else if (tcnt != 4'(`TMIP_TAPS)) begin
			tcnt <= tcnt + 4'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && tcnt != 4'(`TMIP_TAPS)) begin
			tmpl[tcnt] <= template;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			act <= '0;
		end else if (in_valid2 && state == tmip_pkg::SCAN_IDLE) begin
			act <= tmip_pkg::action_t'(action);
		end
	end

	// ========================================
	// scan FSM
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= tmip_pkg::SCAN_IDLE;
			x <= '0;
			y <= '0;
			trow <= '0;
			tcol <= '0;
			drain <= 1'b0;
		end else begin
			case (state)
				tmip_pkg::SCAN_IDLE: begin
					if (in_valid2) begin
						state <= tmip_pkg::SCAN_READ;
					end
				end
				tmip_pkg::SCAN_READ: begin
					// one extra cycle for the last tap to return
					if (drain) begin
						drain <= 1'b0;
						state <= tmip_pkg::SCAN_HOLD;
					end else if (tcol == 2'd2) begin
						tcol <= '0;
						trow <= (trow == 2'd2) ? 2'd0 : trow + 2'd1;
						drain <= (trow == 2'd2);
					end else begin
						tcol <= tcol + 2'd1;
					end
				end
				tmip_pkg::SCAN_HOLD: begin
					if (result_load) begin
						x <= x_last ? 5'd0 : x + 5'd1;
						if (x_last) begin
							y <= y_last ? 5'd0 : y + 5'd1;
						end
						state <= (x_last && y_last) ? tmip_pkg::SCAN_IDLE : tmip_pkg::SCAN_READ;
					end
				end
				default: state <= tmip_pkg::SCAN_IDLE;
			endcase
		end
	end

	// padded taps never issue, so they add nothing
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tap_vld <= 1'b0;
		end else begin
			tap_vld <= rd_en;
		end
	end

	always_ff @(posedge clk) begin
		wt_d <= tmpl[tap_idx];
	end

	always_ff @(posedge clk) begin
		if (tap_vld) begin
			acc <= acc + tmip_pkg::conv_t'(rd_data) * tmip_pkg::conv_t'(wt_d);
		end else if (state == tmip_pkg::SCAN_IDLE || result_load) begin
			acc <= '0;
		end
	end

	a_rd_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
		rd_en |-> ({1'b0, rd_addr} < pix_cnt));

endmodule

`default_nettype wire

/* hw/frame_store.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tmip_config.svh"

module frame_store (
	input  logic                clk,
	input  tmip_pkg::gray_set_t gray,
	input  logic                wr_en,
	input  tmip_pkg::addr_t     wr_addr,
	input  tmip_pkg::action_t   act,
	input  logic                rd_en,
	input  tmip_pkg::addr_t     rd_addr,
	output tmip_pkg::pixel_t    rd_data
);

	localparam int DEPTH = 1 << `TMIP_ADDR_W;

	tmip_pkg::pixel_t mem_max [DEPTH];
	tmip_pkg::pixel_t mem_avg [DEPTH];
	tmip_pkg::pixel_t mem_wgt [DEPTH];
	tmip_pkg::pixel_t sel_pix;

	// all three planes share one write
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_max[wr_addr] <= gray.max_v;
			mem_avg[wr_addr] <= gray.avg_v;
			mem_wgt[wr_addr] <= gray.wgt_v;
		end
	end

	always_comb begin
		case (act.mode)
			tmip_pkg::GRAY_AVG: sel_pix = mem_avg[rd_addr];
			tmip_pkg::GRAY_WGT: sel_pix = mem_wgt[rd_addr];
			default: sel_pix = mem_max[rd_addr];
		endcase
	end

	// negate is 255 - v
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= act.negate ? ~sel_pix : sel_pix;
		end
	end

	a_no_rw_clash: assert property (@(posedge clk)
		!(wr_en && rd_en && wr_addr == rd_addr));

endmodule

`default_nettype wire

/* hw/gray_convert.sv */
`timescale 1ns/10ps
`default_nettype none

module gray_convert (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  tmip_pkg::pixel_t    image,
	input  logic [4:0]          img_edge,
	output tmip_pkg::gray_set_t gray,
	output logic                wr_en,
	output tmip_pkg::addr_t     wr_addr
);

	logic [1:0] phase;
	logic trip_done;
	tmip_pkg::pixel_t r_q, g_q, b_q;
	logic [9:0] rgb_sum;
	logic [8:0] pix_cnt;
	tmip_pkg::addr_t last_addr;

	assign rgb_sum = {2'b00, r_q} + {2'b00, g_q} + {2'b00, b_q};
	assign pix_cnt = {4'b0000, img_edge} * {4'b0000, img_edge};
	assign last_addr = tmip_pkg::addr_t'(pix_cnt - 9'd1);

	// r, g, b phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= '0;
			trip_done <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			phase <= (!in_valid || phase == 2'd2) ? 2'd0 : phase + 2'd1;
			trip_done <= in_valid && phase == 2'd2;
			wr_en <= trip_done;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			case (phase)
				2'd0: r_q <= image;
				2'd1: g_q <= image;
				default: b_q <= image;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (trip_done) begin
			gray.max_v <= (r_q >= g_q && r_q >= b_q) ? r_q : (g_q >= b_q) ? g_q : b_q;
			gray.avg_v <= tmip_pkg::pixel_t'(rgb_sum / 10'd3);
			gray.wgt_v <= (r_q >> 2) + (g_q >> 1) + (b_q >> 2);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_addr <= '0;
		end else if (wr_en) begin
			wr_addr <= (wr_addr == last_addr) ? '0 : wr_addr + 8'd1;
		end else if (!in_valid && !trip_done) begin
			wr_addr <= '0;
		end
	end

	// edge comes from the top, sampled on the first image cycle
	a_wr_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
		{1'b0, wr_addr} < pix_cnt);

endmodule

`default_nettype wire

/* hw/tmip_pkg.sv */
`default_nettype none

`include "tmip_config.svh"

package tmip_pkg;

	typedef logic [`TMIP_PIX_W-1:0] pixel_t;
	typedef logic [`TMIP_ADDR_W-1:0] addr_t;
	typedef logic [`TMIP_CONV_W-1:0] conv_t;

	// plane select, bits 1..0 of the action input
	typedef enum logic [1:0] {
		GRAY_MAX = 2'd0,
		GRAY_AVG = 2'd1,
		GRAY_WGT = 2'd2
	} gray_mode_e;

	typedef struct packed {
		pixel_t max_v;
		pixel_t avg_v;
		pixel_t wgt_v;
	} gray_set_t;

	// negate sits on bit 2
	typedef struct packed {
		logic       negate;
		gray_mode_e mode;
	} action_t;

	typedef enum logic [1:0] {SCAN_IDLE, SCAN_READ, SCAN_HOLD} scan_state_e;

endpackage

`default_nettype wire

/* hw/tmip_config.svh */
`ifndef TMIP_CONFIG_SVH
`define TMIP_CONFIG_SVH

// one colour or gray component
`define TMIP_PIX_W 8

// plane address, 16x16 pixels at most
`define TMIP_ADDR_W 8

// correlation result, 9 x 255 x 255 fits without wrap
`define TMIP_CONV_W 20

// 3x3 window
`define TMIP_TAPS 9

`define TMIP_MAX_EDGE 16

`endif
